//--- accessBridge.f
+incdir+bench
design/accessPkg.sv
design/accessChan.sv
design/requestIssue.sv
design/requestBuffer.sv
design/laneMemory.sv
design/accessBridge.sv
bench/bridgeTb.sv

//--- bench/bridgeModel.svh
// Testbench Galois LFSR and byte-addressed reference memory with the lane rules
`ifndef BRIDGE_MODEL_SVH
`define BRIDGE_MODEL_SVH

localparam logic [31:0] lfsrSeed = 32'ha030_321b;
localparam logic [31:0] lfsrTaps = 32'h8020_0003;  // x^32 + x^22 + x^2 + x + 1

logic [31:0] lfsrState;
logic [7:0]  refMem [2**byteAddrW];  // One entry per byte address, little endian

// One LFSR step per returned bit, first bit ends up most significant
function automatic logic [63:0] takeBits(input int n);
  logic [63:0] val;
  logic        outBit;
  val = '0;
  for (int i = 0; i < n; i++) begin
    outBit    = lfsrState[0];
    lfsrState = {1'b0, lfsrState[31:1]};
    if (outBit) lfsrState = lfsrState ^ lfsrTaps;
    val = (val << 1) | 64'(outBit);
  end
  return val;
endfunction

function automatic void clearModel();
  for (int i = 0; i < 2**byteAddrW; i++) begin
    refMem[i] = 8'h00;
  end
endfunction

// ------------------------------
// Lane rules
// ------------------------------
// Address aligned down to the size, then 1, 2, 4 or 8 bytes from there
function automatic void modelWrite(input accessSize_t sz, input logic [6:0] addr,
                                   input logic [63:0] data);
  int         nBytes;
  logic [6:0] base;
  nBytes = 1 << int'(sz);
  base   = addr & ~7'(nBytes - 1);
  for (int i = 0; i < nBytes; i++) begin
    refMem[base + 7'(i)] = 8'(data >> (8 * i));  // Low data bytes only
  end
endfunction

function automatic logic [63:0] modelRead(input accessSize_t sz, input logic [6:0] addr);
  int          nBytes;
  logic [6:0]  base;
  logic [63:0] val;
  nBytes = 1 << int'(sz);
  base   = addr & ~7'(nBytes - 1);
  val    = '0;                                    // Zero extension
  for (int i = 0; i < nBytes; i++) begin
    val = val | (64'(refMem[base + 7'(i)]) << (8 * i));
  end
  return val;
endfunction

`endif

//--- bench/bridgeTb.sv
// Testbench for accessBridge: clock, reset, directed and random traffic, model checks, watchdog
module bridgeTb;
  import accessPkg::*;

  `include "bridgeModel.svh"

  localparam int clkPeriod    = 4;
  localparam int resetCycles  = 5;
  localparam int randomReqs   = 200;
  localparam int stallCycles  = 16;
  localparam int tailReqs     = 40;
  localparam int totalReqs    = 4 + 12 + 32 + randomReqs + stallCycles + tailReqs;
  localparam int perReqCycles = 40;  // Generous bound incl. response stalls
  localparam int watchLimit   = (resetCycles + totalReqs * perReqCycles + 100) * clkPeriod;

  logic                 dvtFlags;
  logic                 pcFail;
  logic                 reqValid;
  logic                 reqReady;
  logic                 reqWrite;
  accessSize_t          reqSize;
  logic [byteAddrW-1:0] reqAddr;
  logic [dataW-1:0]     reqData;
  logic                 respValid;
  logic                 respReady;
  logic [dataW-1:0]     respData;

  logic [63:0] expQ [$];  // Expected read data in request order
  int          errCount;
  int          checkCount;
  int          stallLeft;
  logic        holdLow;   // Keeps respReady low for the back-pressure phase

  accessBridge u_dut (
    .dvtFlags  (dvtFlags),
    .pcFail    (pcFail),
    .reqValid  (reqValid),
    .reqReady  (reqReady),
    .reqWrite  (reqWrite),
    .reqSize   (reqSize),
    .reqAddr   (reqAddr),
    .reqData   (reqData),
    .respValid (respValid),
    .respReady (respReady),
    .respData  (respData)
  );

  always #(clkPeriod / 2) dvtFlags = ~dvtFlags;

  // ------------------------------
  // Helpers
  // ------------------------------
  task automatic checkValue(input string name, input logic [63:0] got, input logic [63:0] exp);
    checkCount++;
    assert (got === exp) else begin
      errCount++;
      $display("CHECK FAILED %s: got %h expected %h", name, got, exp);
    end
  endtask

  // Response side, run at every falling edge
  task automatic serviceResponse();
    logic [63:0] exp;
    if (holdLow) begin
      respReady = 1'b0;
    end else if (stallLeft > 0) begin
      respReady = 1'b0;
      stallLeft--;
    end else if (3'(takeBits(3)) == 3'd0) begin
      respReady = 1'b0;
      stallLeft = int'(3'(takeBits(3)));  // Stretch of up to 7 more cycles
    end else begin
      respReady = 1'b1;
    end
    if (respValid && respReady) begin       // Accepted at the next rising edge
      checkCount++;
      assert (expQ.size() != 0) else begin
        errCount++;
        $display("Response arrived with no read outstanding");
      end
      if (expQ.size() != 0) begin
        exp = expQ.pop_front();
        checkValue("respData", respData, exp);
      end
    end
  endtask

  task automatic nextCycle();
    @(negedge dvtFlags);
    reqValid = 1'b0;
    serviceResponse();
  endtask

  task automatic recordRequest(input logic wr, input accessSize_t sz, input logic [6:0] addr,
                               input logic [63:0] data);
    if (wr) begin
      modelWrite(sz, addr, data);
    end else begin
      expQ.push_back(modelRead(sz, addr));
      checkCount++;
      assert (expQ.size() <= bufDepth + 2) else begin
        errCount++;
        $display("More than %0d reads accepted but unanswered", bufDepth + 2);
      end
    end
  endtask

  // Holds the request until reqReady is seen at a falling edge
  task automatic sendRequest(input logic wr, input accessSize_t sz, input logic [6:0] addr,
                             input logic [63:0] data);
    nextCycle();
    reqWrite = wr;
    reqSize  = sz;
    reqAddr  = addr;
    reqData  = data;
    reqValid = 1'b1;
    while (!reqReady) begin
      nextCycle();
      reqValid = 1'b1;
    end
    recordRequest(wr, sz, addr, data);
  endtask

  task automatic randomRequest();
    logic        wr;
    accessSize_t sz;
    logic [6:0]  addr;
    logic [63:0] data;
    wr   = 1'(takeBits(1));
    sz   = accessSize_t'(2'(takeBits(2)));
    addr = 7'(takeBits(7));
    data = takeBits(64);
    sendRequest(wr, sz, addr, data);
  endtask

  // respReady low: reads go in until credits run out
  task automatic stallPhase();
    logic        sawStall;
    accessSize_t sz;
    logic [6:0]  addr;
    holdLow  = 1'b1;
    sawStall = 1'b0;
    for (int i = 0; i < stallCycles; i++) begin
      nextCycle();
      if (reqReady) begin
        sz       = accessSize_t'(2'(takeBits(2)));
        addr     = 7'(takeBits(7));
        reqWrite = 1'b0;
        reqSize  = sz;
        reqAddr  = addr;
        reqValid = 1'b1;
        recordRequest(1'b0, sz, addr, 64'h0);
      end else begin
        sawStall = 1'b1;
      end
    end
    checkCount++;
    assert (sawStall) else begin
      errCount++;
      $display("reqReady never fell while respReady was held low");
    end
    holdLow = 1'b0;
  endtask

  // ------------------------------
  // Main sequence
  // ------------------------------
  initial begin
    logic [6:0] addr;
    dvtFlags   = 1'b0;
    pcFail     = 1'b1;
    reqValid   = 1'b0;
    reqWrite   = 1'b0;
    reqSize    = sizeByte;
    reqAddr    = '0;
    reqData    = '0;
    respReady  = 1'b0;
    holdLow    = 1'b0;
    stallLeft  = 0;
    errCount   = 0;
    checkCount = 0;
    lfsrState  = lfsrSeed;
    clearModel();

    repeat (resetCycles) @(posedge dvtFlags);
    @(negedge dvtFlags);
    pcFail = 1'b0;
    checkValue("reqReady", 64'(reqReady), 64'h1);
    checkValue("respValid", 64'(respValid), 64'h0);

    // Cleared memory reads back as zero
    repeat (4) sendRequest(1'b0, sizeDouble, 7'(takeBits(7)), 64'h0);

    // Sub-word write over a known doubleword
    for (int s = 0; s < 4; s++) begin
      addr = 7'(takeBits(7));
      sendRequest(1'b1, sizeDouble, addr, takeBits(64));
      sendRequest(1'b1, accessSize_t'(2'(s)), addr, takeBits(64));
      sendRequest(1'b0, sizeDouble, addr, 64'h0);
    end

    // Lane extraction with random low address bits
    for (int s = 0; s < 4; s++) begin
      repeat (4) begin
        addr = 7'(takeBits(7));
        sendRequest(1'b1, sizeDouble, addr, takeBits(64));
        sendRequest(1'b0, accessSize_t'(2'(s)), {addr[6:3], 3'(takeBits(3))}, 64'h0);
      end
    end

    repeat (randomReqs) randomRequest();
    stallPhase();
    repeat (tailReqs) randomRequest();

    // Drain, then watch for stray responses
    while (expQ.size() != 0) nextCycle();
    repeat (10) nextCycle();
    checkValue("respValid", 64'(respValid), 64'h0);

    $display("checks %0d errors %0d", checkCount, errCount);
    if (errCount == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

  // ------------------------------
  // Watchdog
  // ------------------------------
  initial begin
    #(watchLimit);
    errCount++;
    $display("Watchdog expired after %0d time units, traffic did not complete", watchLimit);
    $display("checks %0d errors %0d", checkCount, errCount);
    $display("RESULT: FAIL");
    $finish;
  end

endmodule

//--- design/accessBridge.sv
// Bridge top: producer, credit FIFO and lane memory joined by two access channels
module accessBridge (
  input  logic                            dvtFlags,
  input  logic                            pcFail,
  input  logic                            reqValid,
  output logic                            reqReady,
  input  logic                            reqWrite,
  input  accessPkg::accessSize_t          reqSize,
  input  logic [accessPkg::byteAddrW-1:0] reqAddr,
  input  logic [accessPkg::dataW-1:0]     reqData,
  output logic                            respValid,
  input  logic                            respReady,
  output logic [accessPkg::dataW-1:0]     respData
);

  // ------------------------------
  // Channels
  // ------------------------------
  accessChan issueChan ();  // Producer to buffer, flow is credit return
  accessChan memChan ();    // Buffer to memory, flow is take

  // ------------------------------
  // Blocks
  // ------------------------------
  requestIssue u_requestIssue (
    .dvtFlags  (dvtFlags),
    .pcFail    (pcFail),
    .reqValid  (reqValid),
    .reqReady  (reqReady),
    .reqWrite  (reqWrite),
    .reqSize   (reqSize),
    .reqAddr   (reqAddr),
    .reqData   (reqData),
    .issueChan (issueChan.sender)
  );

  requestBuffer u_requestBuffer (
    .dvtFlags  (dvtFlags),
    .pcFail    (pcFail),
    .issueChan (issueChan.receiver),
    .memChan   (memChan.sender)
  );

  laneMemory u_laneMemory (
    .dvtFlags  (dvtFlags),
    .pcFail    (pcFail),
    .memChan   (memChan.receiver),
    .respValid (respValid),
    .respReady (respReady),
    .respData  (respData)
  );

endmodule

//--- design/accessChan.sv
// Queued access channel with sender and receiver modports
interface accessChan;
  import accessPkg::*;

  logic                         valid;       // Transfer present
  logic                         write;       // High for write, low for read
  logic [wordAddrW-1:0]         wordAddr;    // Doubleword index
  logic [$clog2(laneCount)-1:0] laneOffset;  // Byte offset, aligned to size
  accessSize_t                  size;
  laneWord_t                    data;        // Replicated across all lanes

  // Return path, credit pulse or take pulse depending on the link
  logic                         flow;

  modport sender (
    output valid,
    output write,
    output wordAddr,
    output laneOffset,
    output size,
    output data,
    input  flow
  );

  modport receiver (
    input  valid,
    input  write,
    input  wordAddr,
    input  laneOffset,
    input  size,
    input  data,
    output flow
  );

endinterface

//--- design/accessPkg.sv
// Bridge widths, buffer depth, access size enum and the lane view union
package accessPkg;

  // ------------------------------
  // Sizes
  // ------------------------------
  localparam int dataW     = 64;  // Memory word and request data
  localparam int laneCount = 8;   // Byte lanes per word
  localparam int wordAddrW = 4;   // 16 doublewords
  localparam int byteAddrW = 7;   // Byte address at the top level
  localparam int bufDepth  = 4;   // Buffer entries, also initial credits
  localparam int creditW   = 3;   // Holds 0 to bufDepth

  // ------------------------------
  // Access size
  // ------------------------------
  typedef enum logic [1:0] {
    sizeByte   = 2'd0,
    sizeHalf   = 2'd1,
    sizeWord   = 2'd2,
    sizeDouble = 2'd3
  } accessSize_t;

  // ------------------------------
  // Lane views of one memory word
  // ------------------------------
  // Same 64 bits seen at byte, half, word or doubleword granularity.
  // Element 0 is always the least significant lane
  typedef union packed {
    logic [laneCount-1:0][7:0]     bytes;
    logic [laneCount/2-1:0][15:0]  halves;
    logic [laneCount/4-1:0][31:0]  words;
    logic [dataW-1:0]              dword;
  } laneWord_t;

endpackage

//--- design/laneMemory.sv
// Consumer: take control, byte enables, 16x64 memory, read lane select, response register
module laneMemory (
  input  logic                        dvtFlags,
  input  logic                        pcFail,
  accessChan.receiver                 memChan,
  output logic                        respValid,
  input  logic                        respReady,
  output logic [accessPkg::dataW-1:0] respData
);
  import accessPkg::*;

  laneWord_t            mem [2**wordAddrW];
  logic                 take;
  logic [laneCount-1:0] byteEn;
  laneWord_t            rdWord;
  logic [dataW-1:0]     rdVal;

  // Take while the response slot is free or draining this cycle
  assign take         = memChan.valid && (!respValid || respReady);
  assign memChan.flow = take;

  // ------------------------------
  // Byte enables
  // ------------------------------
  always_comb begin
    case (memChan.size)
      sizeByte: byteEn = laneCount'(8'h01) << memChan.laneOffset;
      sizeHalf: byteEn = laneCount'(8'h03) << memChan.laneOffset;
      sizeWord: byteEn = laneCount'(8'h0f) << memChan.laneOffset;
      default:  byteEn = '1;
    endcase
  end

  // ------------------------------
  // Memory array
  // ------------------------------
  always_ff @(posedge dvtFlags or posedge pcFail) begin
    if (pcFail) begin
      for (int w = 0; w < 2**wordAddrW; w++) begin
        mem[w] <= '0;
      end
    end else if (take && memChan.write) begin
      // Data is replicated, so each enabled lane already holds its value
      for (int b = 0; b < laneCount; b++) begin
        if (byteEn[b]) mem[memChan.wordAddr].bytes[b] <= memChan.data.bytes[b];
      end
    end
  end

  // ------------------------------
  // Read lane select
  // ------------------------------
  assign rdWord = mem[memChan.wordAddr];

  always_comb begin
    case (memChan.size)
      sizeByte: rdVal = dataW'(rdWord.bytes[memChan.laneOffset]);
      sizeHalf: rdVal = dataW'(rdWord.halves[memChan.laneOffset[2:1]]);
      sizeWord: rdVal = dataW'(rdWord.words[memChan.laneOffset[2]]);
      default:  rdVal = rdWord.dword;
    endcase
  end

  // ------------------------------
  // Response register
  // ------------------------------
  always_ff @(posedge dvtFlags or posedge pcFail) begin
    if (pcFail) begin
      respValid <= 1'b0;
    end else if (take && !memChan.write) begin
      respValid <= 1'b1;               // New read result
    end else if (respReady) begin
      respValid <= 1'b0;
    end
  end

  // Held until accepted, take cannot happen while blocked
  always_ff @(posedge dvtFlags) begin
    if (take && !memChan.write) respData <= rdVal;
  end

endmodule

//--- design/requestBuffer.sv
// Circular request FIFO that returns one credit per popped entry
module requestBuffer (
  input  logic        dvtFlags,
  input  logic        pcFail,
  accessChan.receiver issueChan,
  accessChan.sender   memChan
);
  import accessPkg::*;

  // One storage array per entry field
  logic                         entWrite [bufDepth];
  logic [wordAddrW-1:0]         entAddr  [bufDepth];
  logic [$clog2(laneCount)-1:0] entOff   [bufDepth];
  accessSize_t                  entSize  [bufDepth];
  laneWord_t                    entData  [bufDepth];

  logic [$clog2(bufDepth)-1:0]  wrPtr;
  logic [$clog2(bufDepth)-1:0]  rdPtr;
  logic [creditW-1:0]           fill;     // Entries held
  logic                         push;
  logic                         pop;

  assign push = issueChan.valid;  // Credits guarantee a free slot
  assign pop  = memChan.flow;     // Consumer only takes a shown entry

  // ------------------------------
  // Pointers and fill level
  // ------------------------------
  always_ff @(posedge dvtFlags or posedge pcFail) begin
    if (pcFail) begin
      wrPtr <= '0;
      rdPtr <= '0;
      fill  <= '0;
    end else begin
      if (push) wrPtr <= wrPtr + ($clog2(bufDepth))'(1);  // Depth is a power of two
      if (pop)  rdPtr <= rdPtr + ($clog2(bufDepth))'(1);
      fill <= fill + creditW'(push) - creditW'(pop);
    end
  end

  always_ff @(posedge dvtFlags) begin
    if (push) begin
      entWrite[wrPtr] <= issueChan.write;
      entAddr[wrPtr]  <= issueChan.wordAddr;
      entOff[wrPtr]   <= issueChan.laneOffset;
      entSize[wrPtr]  <= issueChan.size;
      entData[wrPtr]  <= issueChan.data;
    end
  end

  // ------------------------------
  // Oldest entry out
  // ------------------------------
  assign memChan.valid      = (fill != '0);
  assign memChan.write      = entWrite[rdPtr];
  assign memChan.wordAddr   = entAddr[rdPtr];
  assign memChan.laneOffset = entOff[rdPtr];
  assign memChan.size       = entSize[rdPtr];
  assign memChan.data       = entData[rdPtr];

  // Credit goes back in the take cycle
  assign issueChan.flow = pop;

endmodule

//--- design/requestIssue.sv
// Request producer: credit counter, address split, size alignment, data replication
module requestIssue (
  input  logic                            dvtFlags,
  input  logic                            pcFail,
  input  logic                            reqValid,
  output logic                            reqReady,
  input  logic                            reqWrite,
  input  accessPkg::accessSize_t          reqSize,
  input  logic [accessPkg::byteAddrW-1:0] reqAddr,
  input  logic [accessPkg::dataW-1:0]     reqData,
  accessChan.sender                       issueChan
);
  import accessPkg::*;

  logic [creditW-1:0]           creditCnt;
  logic                         accept;
  logic [$clog2(laneCount)-1:0] rawOff;
  logic [$clog2(laneCount)-1:0] alignedOff;
  laneWord_t                    repData;

  // ------------------------------
  // Credits
  // ------------------------------
  assign reqReady = (creditCnt != '0);
  assign accept   = reqValid && reqReady;

  // The credit is taken at acceptance, it covers the valid cycle that follows
  always_ff @(posedge dvtFlags or posedge pcFail) begin
    if (pcFail) begin
      creditCnt       <= creditW'(bufDepth);
      issueChan.valid <= 1'b0;
    end else begin
      creditCnt       <= creditCnt + creditW'(issueChan.flow) - creditW'(accept);
      issueChan.valid <= accept;
    end
  end

  // ------------------------------
  // Alignment and replication
  // ------------------------------
  assign rawOff = reqAddr[byteAddrW-wordAddrW-1:0];

  always_comb begin
    case (reqSize)
      sizeByte: alignedOff = rawOff;
      sizeHalf: alignedOff = {rawOff[2:1], 1'b0};
      sizeWord: alignedOff = {rawOff[2], 2'b00};
      default:  alignedOff = '0;  // Doubleword covers all lanes
    endcase
  end

  always_comb begin
    repData.dword = reqData;
    case (reqSize)
      sizeByte: repData.bytes  = {laneCount{reqData[7:0]}};
      sizeHalf: repData.halves = {(laneCount/2){reqData[15:0]}};
      sizeWord: repData.words  = {(laneCount/4){reqData[31:0]}};
      default:  repData.dword  = reqData;
    endcase
  end

  // Payload follows valid by the same single cycle
  always_ff @(posedge dvtFlags) begin
    if (accept) begin
      issueChan.write      <= reqWrite;
      issueChan.wordAddr   <= reqAddr[byteAddrW-1:byteAddrW-wordAddrW];
      issueChan.laneOffset <= alignedOff;
      issueChan.size       <= reqSize;
      issueChan.data       <= repData;
    end
  end

endmodule

//--- run.sh
#!/usr/bin/env bash
# Build with Verilator, run, and decide pass or fail from the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -f accessBridge.f --top-module bridgeTb -o bridgeSim \
  && ./obj_dir/bridgeSim > sim.log 2>&1 \
  || { echo "Build or simulation failed"; cat sim.log 2>/dev/null; exit 1; }

cat sim.log
grep -q "^RESULT: PASS$" sim.log && exit 0 || exit 1
